/* include/bus_macros.svh */
`ifndef BUS_MACROS_SVH
`define BUS_MACROS_SVH

// address map of the system bus
// regions are told apart by address bits 31 to 16 only
`define REGION_SHIFT 16

// exception vectors, 32 words
`define VECT_BASE 32'h0000_0000
`define VECT_WORDS_LOG2 5

// scratch RAM, 1024 words
`define SCRATCH_BASE 32'h0001_0000
`define SCRATCH_WORDS_LOG2 10

// I/O register block with four registers:
//   0 leds, 1 switches, 2 fault count, 3 last fault address
`define IO_BASE 32'h0002_0000

`endif

/* design/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  // bit n enables data byte n
  typedef logic [3:0] be_t;

  typedef struct packed {
    addr_t addr;
    data_t wdata;
    be_t   be;
    logic  read;
    logic  write;
  } bus_req_t;

  typedef struct packed {
    data_t rdata;
    logic  fault;
  } bus_rsp_t;

  typedef enum logic [2:0] {
    chip_none,
    chip_vectors,
    chip_scratch,
    chip_io,
    chip_unmapped
  } chip_t;

  typedef enum logic [1:0] {
    st_idle,
    st_access,
    st_respond
  } mmu_state_t;

endpackage

`default_nettype wire

/* design/bus_arbiter.sv */
`default_nettype none

module bus_arbiter (
  input  wire                 clock_50,
  input  wire                 rst_n,
  input  wire bus_pkg::bus_req_t cpu_req,
  input  wire bus_pkg::bus_req_t dbg_req,
  input  wire                 done,
  input  wire bus_pkg::bus_rsp_t bus_rsp,
  output bus_pkg::bus_req_t   bus_req,
  output logic                bus_valid,
  output bus_pkg::bus_rsp_t   cpu_rsp,
  output bus_pkg::bus_rsp_t   dbg_rsp,
  output logic                cpu_wait,
  output logic                dbg_wait
);

  logic cpu_pend;
  logic dbg_pend;
  logic grant_dbg;
  // which master had the bus last, for round robin
  logic last_dbg;

  assign cpu_pend = cpu_req.read | cpu_req.write;
  assign dbg_pend = dbg_req.read | dbg_req.write;

  // grant is taken only while the bus is idle and held until done
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      bus_valid <= 1'b0;
      grant_dbg <= 1'b0;
      last_dbg  <= 1'b0;
    end else if (!bus_valid) begin
      // on contention the master not served last wins
      grant_dbg <= dbg_pend & (~cpu_pend | ~last_dbg);
      bus_valid <= cpu_pend | dbg_pend;
    end else if (done) begin
      bus_valid <= 1'b0;
      last_dbg  <= grant_dbg;
      grant_dbg <= 1'b0;
    end
  end

  assign bus_req = grant_dbg ? dbg_req : cpu_req;

  // response only goes to the granted master
  assign cpu_rsp = (bus_valid && !grant_dbg) ? bus_rsp : '0;
  assign dbg_rsp = (bus_valid && grant_dbg) ? bus_rsp : '0;

  // wait drops only in the cycle the transfer completes
  assign cpu_wait = cpu_pend & ~(bus_valid & ~grant_dbg & done);
  assign dbg_wait = dbg_pend & ~(bus_valid & grant_dbg & done);

  // the granted request must hold still for the whole transfer
  a_req_stable : assert property (@(posedge clock_50) disable iff (!rst_n)
    bus_valid && $past(bus_valid) |-> $stable(bus_req))
    else $error("bus_req changed during a transfer");

  a_no_read_write : assert property (@(posedge clock_50) disable iff (!rst_n)
    !(cpu_req.read && cpu_req.write) && !(dbg_req.read && dbg_req.write))
    else $error("master asserted read and write together");

endmodule

`default_nettype wire

/* design/mmu.sv */
`default_nettype none

`include "bus_macros.svh"

module mmu (
  input  wire                 clock_50,
  input  wire                 rst_n,
  input  wire bus_pkg::bus_req_t bus_req,
  input  wire                 bus_valid,
  output logic                start,
  output logic                done,
  output bus_pkg::bus_rsp_t   bus_rsp,
  output bus_pkg::addr_t      word_addr,
  output bus_pkg::data_t      wdata,
  output bus_pkg::be_t        be,
  output logic                vect_read,
  output logic                vect_write,
  output logic                scratch_read,
  output logic                scratch_write,
  output logic                io_read,
  output logic                io_write,
  input  wire bus_pkg::data_t vect_rdata,
  input  wire bus_pkg::data_t scratch_rdata,
  input  wire bus_pkg::data_t io_rdata,
  output logic                fault_strobe,
  output bus_pkg::addr_t      fault_addr
);

  bus_pkg::mmu_state_t state;
  bus_pkg::chip_t      chip_dec;
  bus_pkg::chip_t      chip_r;
  bus_pkg::addr_t      region;
  logic                access;

  assign region = bus_req.addr >> `REGION_SHIFT;

  always_comb begin
    if (region == (`VECT_BASE >> `REGION_SHIFT))
      chip_dec = bus_pkg::chip_vectors;
    else if (region == (`SCRATCH_BASE >> `REGION_SHIFT))
      chip_dec = bus_pkg::chip_scratch;
    else if (region == (`IO_BASE >> `REGION_SHIFT))
      chip_dec = bus_pkg::chip_io;
    else
      chip_dec = bus_pkg::chip_unmapped;
  end

  // idle -> access -> respond -> idle, chip latched on the way in
  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      state  <= bus_pkg::st_idle;
      chip_r <= bus_pkg::chip_none;
    end else begin
      case (state)
        bus_pkg::st_idle: begin
          if (bus_valid) begin
            state  <= bus_pkg::st_access;
            chip_r <= chip_dec;
          end
        end
        bus_pkg::st_access:
          state <= bus_pkg::st_respond;
        default: begin
          state  <= bus_pkg::st_idle;
          chip_r <= bus_pkg::chip_none;
        end
      endcase
    end
  end

  assign access = (state == bus_pkg::st_access);
  assign start  = access;
  assign done   = (state == bus_pkg::st_respond);

  assign word_addr = {2'b00, bus_req.addr[31:2]};
  assign wdata     = bus_req.wdata;
  assign be        = bus_req.be;

  assign vect_read     = access && chip_r == bus_pkg::chip_vectors && bus_req.read;
  assign vect_write    = access && chip_r == bus_pkg::chip_vectors && bus_req.write;
  assign scratch_read  = access && chip_r == bus_pkg::chip_scratch && bus_req.read;
  assign scratch_write = access && chip_r == bus_pkg::chip_scratch && bus_req.write;
  assign io_read       = access && chip_r == bus_pkg::chip_io && bus_req.read;
  assign io_write      = access && chip_r == bus_pkg::chip_io && bus_req.write;

  // unmapped access gets no strobe, only a note in the fault log
  assign fault_strobe = access && chip_r == bus_pkg::chip_unmapped;
  assign fault_addr   = bus_req.addr;

  always_comb begin
    case (chip_r)
      bus_pkg::chip_vectors: bus_rsp.rdata = vect_rdata;
      bus_pkg::chip_scratch: bus_rsp.rdata = scratch_rdata;
      bus_pkg::chip_io:      bus_rsp.rdata = io_rdata;
      default:               bus_rsp.rdata = '0;
    endcase
    bus_rsp.fault = done && chip_r == bus_pkg::chip_unmapped;
  end

  a_one_strobe : assert property (@(posedge clock_50) disable iff (!rst_n)
    $onehot0({vect_read, vect_write, scratch_read, scratch_write, io_read, io_write}))
    else $error("more than one slave strobe active");

  // the arbiter must still hold the transfer from start through done
  a_done_after_start : assert property (@(posedge clock_50) disable iff (!rst_n)
    start |-> bus_valid ##1 (done && bus_valid))
    else $error("done did not follow start within the granted transfer");

endmodule

`default_nettype wire

/* design/scratch_ram.sv */
`default_nettype none

`include "bus_macros.svh"

module scratch_ram (
  input  wire                 clock_50,
  input  wire                 read,
  input  wire                 write,
  input  wire bus_pkg::addr_t word_addr,
  input  wire bus_pkg::data_t wdata,
  input  wire bus_pkg::be_t   be,
  output bus_pkg::data_t      rdata
);

  bus_pkg::data_t mem [0:(1 << `SCRATCH_WORDS_LOG2) - 1];
  logic [`SCRATCH_WORDS_LOG2-1:0] idx;

  // region bits above the depth alias
  assign idx = word_addr[`SCRATCH_WORDS_LOG2-1:0];

  always_ff @(posedge clock_50) begin
    if (write) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i])
          mem[idx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  // read data is held until the next read
  always_ff @(posedge clock_50) begin
    if (read)
      rdata <= mem[idx];
  end

endmodule

`default_nettype wire

/* design/vector_ram.sv */
`default_nettype none

`include "bus_macros.svh"

module vector_ram (
  input  wire                 clock_50,
  input  wire                 read,
  input  wire                 write,
  input  wire                 unlock,
  input  wire bus_pkg::addr_t word_addr,
  input  wire bus_pkg::data_t wdata,
  output bus_pkg::data_t      rdata
);

  bus_pkg::data_t mem [0:(1 << `VECT_WORDS_LOG2) - 1];
  logic [`VECT_WORDS_LOG2-1:0] idx;

  assign idx = word_addr[`VECT_WORDS_LOG2-1:0];

  // full word writes, dropped silently while locked
  always_ff @(posedge clock_50) begin
    if (write && unlock)
      mem[idx] <= wdata;
  end

  always_ff @(posedge clock_50) begin
    if (read)
      rdata <= mem[idx];
  end

endmodule

`default_nettype wire

/* design/io_regs.sv */
`default_nettype none

module io_regs (
  input  wire                 clock_50,
  input  wire                 rst_n,
  input  wire                 read,
  input  wire                 write,
  input  wire bus_pkg::addr_t word_addr,
  input  wire bus_pkg::data_t wdata,
  input  wire bus_pkg::be_t   be,
  output bus_pkg::data_t      rdata,
  input  wire [15:0]          switches,
  output logic [15:0]         leds,
  input  wire                 fault_strobe,
  input  wire bus_pkg::addr_t fault_addr
);

  bus_pkg::data_t fault_count;
  bus_pkg::addr_t last_fault;
  logic [1:0]     sel;

  // four registers, the rest of the region aliases
  assign sel = word_addr[1:0];

  always_ff @(posedge clock_50) begin
    if (!rst_n) begin
      leds        <= '0;
      fault_count <= '0;
      last_fault  <= '0;
    end else begin
      // leds only span the two low bytes
      if (write && sel == 2'd0) begin
        for (int i = 0; i < 2; i++) begin
          if (be[i])
            leds[8*i +: 8] <= wdata[8*i +: 8];
        end
      end
      // any write to the count clears it
      if (write && sel == 2'd2)
        fault_count <= '0;
      else if (fault_strobe)
        fault_count <= fault_count + 1'b1;
      if (fault_strobe)
        last_fault <= fault_addr;
    end
  end

  always_ff @(posedge clock_50) begin
    if (read) begin
      case (sel)
        2'd0:    rdata <= {16'h0000, leds};
        2'd1:    rdata <= {16'h0000, switches};
        2'd2:    rdata <= fault_count;
        default: rdata <= last_fault;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/soc_bus.sv */
`default_nettype none

module soc_bus (
  input  wire                    clock_50,
  input  wire                    rst_n,
  input  wire bus_pkg::bus_req_t cpu_req,
  output bus_pkg::bus_rsp_t      cpu_rsp,
  output logic                   cpu_wait,
  input  wire bus_pkg::bus_req_t dbg_req,
  output bus_pkg::bus_rsp_t      dbg_rsp,
  output logic                   dbg_wait,
  input  wire                    vect_unlock,
  input  wire [15:0]             switches,
  output logic [15:0]            leds
);

  bus_pkg::bus_req_t bus_req;
  bus_pkg::bus_rsp_t bus_rsp;
  bus_pkg::addr_t    word_addr;
  bus_pkg::addr_t    fault_addr;
  bus_pkg::data_t    wdata;
  bus_pkg::data_t    vect_rdata;
  bus_pkg::data_t    scratch_rdata;
  bus_pkg::data_t    io_rdata;
  bus_pkg::be_t      be;
  logic bus_valid;
  logic done;
  logic fault_strobe;
  logic vect_read;
  logic vect_write;
  logic scratch_read;
  logic scratch_write;
  logic io_read;
  logic io_write;

  bus_arbiter arb0 (
    .clock_50(clock_50), .rst_n(rst_n), .cpu_req(cpu_req), .dbg_req(dbg_req),
    .done(done), .bus_rsp(bus_rsp), .bus_req(bus_req), .bus_valid(bus_valid),
    .cpu_rsp(cpu_rsp), .dbg_rsp(dbg_rsp), .cpu_wait(cpu_wait), .dbg_wait(dbg_wait)
  );

  // no slave takes the start pulse
  mmu mmu0 (
    .clock_50(clock_50), .rst_n(rst_n), .bus_req(bus_req), .bus_valid(bus_valid),
    .start(), .done(done), .bus_rsp(bus_rsp), .word_addr(word_addr),
    .wdata(wdata), .be(be),
    .vect_read(vect_read), .vect_write(vect_write),
    .scratch_read(scratch_read), .scratch_write(scratch_write),
    .io_read(io_read), .io_write(io_write),
    .vect_rdata(vect_rdata), .scratch_rdata(scratch_rdata), .io_rdata(io_rdata),
    .fault_strobe(fault_strobe), .fault_addr(fault_addr)
  );

  scratch_ram ram0 (
    .clock_50(clock_50), .read(scratch_read), .write(scratch_write),
    .word_addr(word_addr), .wdata(wdata), .be(be), .rdata(scratch_rdata)
  );

  vector_ram vecram0 (
    .clock_50(clock_50), .read(vect_read), .write(vect_write), .unlock(vect_unlock),
    .word_addr(word_addr), .wdata(wdata), .rdata(vect_rdata)
  );

  io_regs io0 (
    .clock_50(clock_50), .rst_n(rst_n), .read(io_read), .write(io_write),
    .word_addr(word_addr), .wdata(wdata), .be(be), .rdata(io_rdata),
    .switches(switches), .leds(leds),
    .fault_strobe(fault_strobe), .fault_addr(fault_addr)
  );

endmodule

`default_nettype wire

/* testbench/soc_bus_tb.sv */
`default_nettype none

`include "bus_macros.svh"

module soc_bus_tb;

  localparam int TIMEOUT_EDGES = 20;
  localparam int MAX_LATENCY = 7;

  logic              clock_50;
  logic              rst_n;
  bus_pkg::bus_req_t cpu_req;
  bus_pkg::bus_req_t dbg_req;
  bus_pkg::bus_rsp_t cpu_rsp;
  bus_pkg::bus_rsp_t dbg_rsp;
  logic              cpu_wait;
  logic              dbg_wait;
  logic              vect_unlock;
  logic [15:0]       switches;
  logic [15:0]       leds;

  // reference model of the slaves
  bus_pkg::data_t scratch_m [0:(1 << `SCRATCH_WORDS_LOG2) - 1];
  bus_pkg::data_t vect_m [0:(1 << `VECT_WORDS_LOG2) - 1];
  logic [15:0]    leds_m;
  bus_pkg::data_t fault_count_m;
  bus_pkg::addr_t last_fault_m;
  int             errors;

  soc_bus uut (
    .clock_50(clock_50), .rst_n(rst_n),
    .cpu_req(cpu_req), .cpu_rsp(cpu_rsp), .cpu_wait(cpu_wait),
    .dbg_req(dbg_req), .dbg_rsp(dbg_rsp), .dbg_wait(dbg_wait),
    .vect_unlock(vect_unlock), .switches(switches), .leds(leds)
  );

  initial begin
    clock_50 = 1'b0;
    forever #50 clock_50 = ~clock_50;
  end

  task automatic finish_run();
    $display("errors: %0d", errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  endtask

  task automatic compare_value(input string name, input bus_pkg::data_t got,
                               input bus_pkg::data_t exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  // distinct for every word, built from the full byte address
  function automatic bus_pkg::data_t fill_word(input bus_pkg::addr_t addr);
    return {addr[15:0] ^ 16'h5ac3, addr[31:16] ^ ~addr[15:0]};
  endfunction

  // each master owns 16 scratch words, 512 words apart
  function automatic bus_pkg::addr_t scratch_slot(input int m, input int w);
    return `SCRATCH_BASE + 32'((512 * m + w) * 4);
  endfunction

  function automatic bus_pkg::addr_t unmapped_addr();
    return {16'($urandom_range(16'hffff, 3)), 14'($urandom), 2'b00};
  endfunction

  // expected response from the map rules, then the model update
  task automatic check_response(input string who, input bus_pkg::bus_req_t req,
                                input bus_pkg::bus_rsp_t rsp);
    bus_pkg::addr_t                 region;
    bus_pkg::data_t                 exp;
    logic                           fault_exp;
    logic [`VECT_WORDS_LOG2-1:0]    vidx;
    logic [`SCRATCH_WORDS_LOG2-1:0] sidx;
    region = req.addr >> `REGION_SHIFT;
    exp = '0;
    fault_exp = 1'b0;
    if (region == (`VECT_BASE >> `REGION_SHIFT)) begin
      vidx = req.addr[`VECT_WORDS_LOG2+1:2];
      exp = vect_m[vidx];
      if (req.write && vect_unlock)
        vect_m[vidx] = req.wdata;
    end else if (region == (`SCRATCH_BASE >> `REGION_SHIFT)) begin
      sidx = req.addr[`SCRATCH_WORDS_LOG2+1:2];
      exp = scratch_m[sidx];
      for (int i = 0; i < 4; i++) begin
        if (req.write && req.be[i])
          scratch_m[sidx][8*i +: 8] = req.wdata[8*i +: 8];
      end
    end else if (region == (`IO_BASE >> `REGION_SHIFT)) begin
      case (req.addr[3:2])
        2'd0:    exp = {16'h0000, leds_m};
        2'd1:    exp = {16'h0000, switches};
        2'd2:    exp = fault_count_m;
        default: exp = last_fault_m;
      endcase
      if (req.write && req.addr[3:2] == 2'd0) begin
        for (int i = 0; i < 2; i++) begin
          if (req.be[i])
            leds_m[8*i +: 8] = req.wdata[8*i +: 8];
        end
        compare_value("leds", 32'(leds), 32'(leds_m));
      end
      if (req.write && req.addr[3:2] == 2'd2)
        fault_count_m = '0;
    end else begin
      fault_exp = 1'b1;
      fault_count_m = fault_count_m + 32'd1;
      last_fault_m = req.addr;
    end
    if (req.read || fault_exp)
      compare_value({who, ".rdata"}, rsp.rdata, exp);
    compare_value({who, ".fault"}, 32'(rsp.fault), 32'(fault_exp));
  endtask

  // request on a rising edge, held until wait is seen low at a falling edge
  task automatic bus_access(input int m, input bus_pkg::addr_t addr,
                            input bus_pkg::data_t wdata, input bus_pkg::be_t be,
                            input logic write);
    bus_pkg::bus_req_t req;
    bus_pkg::bus_rsp_t rsp;
    string             who;
    logic              wt;
    int                edges;
    req.addr = addr;
    req.wdata = wdata;
    req.be = be;
    req.read = ~write;
    req.write = write;
    who = (m == 0) ? "cpu" : "dbg";
    @(posedge clock_50);
    if (m == 0)
      cpu_req <= req;
    else
      dbg_req <= req;
    edges = 0;
    wt = 1'b1;
    while (wt) begin
      @(negedge clock_50);
      wt = (m == 0) ? cpu_wait : dbg_wait;
      rsp = (m == 0) ? cpu_rsp : dbg_rsp;
      if (wt) begin
        edges++;
        if (edges > TIMEOUT_EDGES) begin
          $display("timeout: %s transfer to %h never completed", who, addr);
          errors++;
          finish_run();
        end
      end
    end
    if (edges > MAX_LATENCY) begin
      $display("%s transfer to %h took %0d edges, more than %0d", who, addr, edges,
               MAX_LATENCY);
      errors++;
    end
    check_response(who, req, rsp);
  endtask

  task automatic release_bus(input int m);
    @(posedge clock_50);
    if (m == 0)
      cpu_req <= '0;
    else
      dbg_req <= '0;
  endtask

  task automatic scratch_traffic(input int m, input int count);
    bus_pkg::addr_t addr;
    for (int w = 0; w < 16; w++)
      bus_access(m, scratch_slot(m, w), fill_word(scratch_slot(m, w)), 4'hf, 1'b1);
    for (int n = 0; n < count; n++) begin
      addr = scratch_slot(m, int'($urandom_range(15, 0)));
      bus_access(m, addr, $urandom, 4'($urandom), 1'b1);
      addr = scratch_slot(m, int'($urandom_range(15, 0)));
      bus_access(m, addr, 32'h0, 4'h0, 1'b0);
    end
    release_bus(m);
  endtask

  // write a random vector word, then read the same word back
  task automatic vector_traffic(input int m, input int count);
    bus_pkg::addr_t addr;
    for (int n = 0; n < count; n++) begin
      addr = `VECT_BASE + 32'($urandom_range(31, 0) * 4);
      bus_access(m, addr, $urandom, 4'hf, 1'b1);
      bus_access(m, addr, 32'h0, 4'h0, 1'b0);
    end
    release_bus(m);
  endtask

  // back to back requests, the two masters never share model state
  task automatic mixed_traffic(input int m, input int count);
    int kind;
    for (int n = 0; n < count; n++) begin
      kind = int'($urandom_range(3, 0));
      if (kind < 2)
        bus_access(m, scratch_slot(m, int'($urandom_range(15, 0))), $urandom,
                   4'($urandom), 1'(kind));
      else if (m == 0 && kind == 2)
        bus_access(0, `VECT_BASE + 32'($urandom_range(31, 0) * 4), $urandom, 4'hf,
                   1'($urandom));
      else if (m == 0)
        bus_access(0, `IO_BASE, $urandom, 4'($urandom), 1'($urandom));
      else if (kind == 2)
        bus_access(1, unmapped_addr(), $urandom, 4'hf, 1'($urandom));
      else
        bus_access(1, `IO_BASE + 32'($urandom_range(3, 1) * 4), 32'h0, 4'h0, 1'b0);
    end
    release_bus(m);
  endtask

  initial begin
    void'($urandom(46));
    errors = 0;
    rst_n = 1'b0;
    cpu_req = '0;
    dbg_req = '0;
    vect_unlock = 1'b1;
    switches = 16'h0000;
    leds_m = '0;
    fault_count_m = '0;
    last_fault_m = '0;
    repeat (5) @(posedge clock_50);
    rst_n <= 1'b1;
    @(negedge clock_50);
    compare_value("leds", 32'(leds), 32'h0);
    compare_value("cpu_wait", 32'(cpu_wait), 32'h0);
    compare_value("dbg_wait", 32'(dbg_wait), 32'h0);
    bus_access(0, `IO_BASE, 32'h0, 4'h0, 1'b0);
    release_bus(0);

    fork
      scratch_traffic(0, 40);
      scratch_traffic(1, 40);
    join

    for (int w = 0; w < 32; w++)
      bus_access(0, `VECT_BASE + 32'(w * 4), fill_word(`VECT_BASE + 32'(w * 4)), 4'hf, 1'b1);
    release_bus(0);
    vect_unlock <= 1'b0;
    vector_traffic(1, 16);
    vect_unlock <= 1'b1;
    vector_traffic(1, 16);

    for (int n = 0; n < 8; n++) begin
      bus_access(0, `IO_BASE, $urandom, 4'($urandom), 1'b1);
      bus_access(0, `IO_BASE, 32'h0, 4'h0, 1'b0);
    end
    for (int n = 0; n < 4; n++) begin
      release_bus(0);
      switches <= 16'($urandom);
      bus_access(0, `IO_BASE + 32'h4, 32'h0, 4'h0, 1'b0);
    end
    release_bus(0);

    for (int n = 0; n < 10; n++)
      bus_access(1, unmapped_addr(), $urandom, 4'hf, 1'($urandom));
    bus_access(1, `IO_BASE + 32'h8, 32'h0, 4'h0, 1'b0);
    bus_access(1, `IO_BASE + 32'hc, 32'h0, 4'h0, 1'b0);
    // any write clears the fault count
    bus_access(1, `IO_BASE + 32'h8, $urandom, 4'hf, 1'b1);
    bus_access(1, `IO_BASE + 32'h8, 32'h0, 4'h0, 1'b0);
    release_bus(1);

    fork
      mixed_traffic(0, 60);
      mixed_traffic(1, 60);
    join
    finish_run();
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
design/bus_pkg.sv
design/bus_arbiter.sv
design/mmu.sv
design/scratch_ram.sv
design/vector_ram.sv
design/io_regs.sv
design/soc_bus.sv
testbench/soc_bus_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_bus_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
